/* verilog/mem_sys_pkg.sv */
/* Shared definitions for the cache memory system
   Address split, cache and memory sizes, way and memory command structs,
   and the cache controller states */
`default_nettype none

package mem_sys_pkg;

   localparam int ADDR_W         = 16;
   localparam int DATA_W         = 16;
   localparam int TAG_W          = 5;
   localparam int INDEX_W        = 8;
   localparam int OFFSET_W       = 3;
   localparam int NUM_SETS       = 1 << INDEX_W;
   localparam int NUM_WAYS       = 2;
   localparam int WORDS_PER_LINE = 4;
   localparam int WORD_SEL_W     = $clog2(WORDS_PER_LINE);
   localparam int NUM_BANKS      = 4;
   localparam int BANK_W         = $clog2(NUM_BANKS);
   localparam int MEM_LATENCY    = 4;
   localparam int BUSY_W         = $clog2(MEM_LATENCY);
   localparam int MEM_WORDS      = 32768;
   localparam int WORD_AW        = $clog2(MEM_WORDS);
   // Refill issues one read per word, last word lands MEM_LATENCY later
   localparam int FILL_CYCLES    = MEM_LATENCY + WORDS_PER_LINE;
   localparam int CNT_W          = $clog2(FILL_CYCLES);

   // Decoded byte address, offset bit 0 must be zero
   typedef struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
   } addr_fields_t;

   typedef struct packed {
      logic                  enable;
      logic                  comp;
      logic                  write;
      logic [TAG_W-1:0]      tag_in;
      logic [INDEX_W-1:0]    index;
      logic [WORD_SEL_W-1:0] word;
      logic [DATA_W-1:0]     data_in;
      logic                  valid_in;
   } way_cmd_t;

   typedef struct packed {
      logic              hit;
      logic              valid;
      logic              dirty;
      logic [TAG_W-1:0]  tag_out;
      logic [DATA_W-1:0] data_out;
   } way_stat_t;

   typedef struct packed {
      logic               rd;
      logic               wr;
      logic [WORD_AW-1:0] addr;
      logic [DATA_W-1:0]  wdata;
   } mem_req_t;

   typedef enum logic [2:0] {
      IDLE,
      COMPARE,
      WRITE_BACK,
      FILL,
      FINISH
   } ctrl_state_t;

endpackage

`default_nettype wire

/* verilog/cache_way.sv */
/* One way of the two-way cache
   Per-set tag, valid and dirty bits with a four-word line store,
   combinational compare and read, writes at the clock edge */
`timescale 1ns/10ps
`default_nettype none

module cache_way
   import mem_sys_pkg::*;
(
   input  wire            clk,
   input  wire            rst,
   input  wire way_cmd_t  cmd,
   input  wire            we,
   output way_stat_t      stat
);

   logic [TAG_W-1:0]    tag_arr  [NUM_SETS];
   logic [DATA_W-1:0]   data_arr [NUM_SETS][WORDS_PER_LINE];
   logic [NUM_SETS-1:0] valid_arr;
   logic [NUM_SETS-1:0] dirty_arr;
   logic                tag_match;
   logic                hit;
   logic                store;

   assign tag_match = (tag_arr[cmd.index] == cmd.tag_in);
   assign hit       = cmd.enable & cmd.comp & valid_arr[cmd.index] & tag_match;

   always_comb begin
      stat.hit      = hit;
      stat.valid    = valid_arr[cmd.index];
      stat.dirty    = dirty_arr[cmd.index];
      stat.tag_out  = tag_arr[cmd.index];
      stat.data_out = data_arr[cmd.index][cmd.word];
   end

   // Compare writes only land on a hit, fills always land
   assign store = cmd.enable & we & cmd.write & (~cmd.comp | hit);

   always_ff @(posedge clk) begin
      if (store) begin
         data_arr[cmd.index][cmd.word] <= cmd.data_in;
         if (!cmd.comp) begin
            tag_arr[cmd.index] <= cmd.tag_in;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_arr <= '0;
         dirty_arr <= '0;
      end else if (store) begin
         if (cmd.comp) begin
            dirty_arr[cmd.index] <= 1'b1;
         end else begin
            // Refill word, line turns valid with its last word
            valid_arr[cmd.index] <= cmd.valid_in;
            dirty_arr[cmd.index] <= 1'b0;
         end
      end
   end

   // Controller selects a way only during an enabled access
   a_we_with_enable: assert property (@(posedge clk) disable iff (rst)
      we |-> cmd.enable);

endmodule

`default_nettype wire

/* verilog/bank_mem.sv */
/* Four-bank word-interleaved main memory
   Fixed-latency read pipeline, immediate writes,
   per-bank busy countdown and busy-conflict error */
`timescale 1ns/10ps
`default_nettype none

module bank_mem
   import mem_sys_pkg::*;
(
   input  wire                  clk,
   input  wire                  rst,
   input  wire mem_req_t        req,
   output logic [DATA_W-1:0]    rd_data,
   output logic [NUM_BANKS-1:0] busy,
   output logic                 err
);

   logic [DATA_W-1:0]    mem [MEM_WORDS];
   logic [MEM_WORDS-1:0] written;
   logic [DATA_W-1:0]    rd_pipe [MEM_LATENCY];
   logic [BUSY_W-1:0]    busy_cnt [NUM_BANKS];
   logic [BANK_W-1:0]    bank;
   logic                 access;

   assign bank   = req.addr[BANK_W-1:0];
   assign access = req.rd | req.wr;

   always_ff @(posedge clk) begin
      if (req.wr) begin
         mem[req.addr] <= req.wdata;
      end
   end

   // Unwritten words read as zero after reset
   always_ff @(posedge clk) begin
      if (rst) begin
         written <= '0;
      end else if (req.wr) begin
         written[req.addr] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      rd_pipe[0] <= (req.rd && written[req.addr]) ? mem[req.addr] : '0;
      for (int i = 1; i < MEM_LATENCY; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rd_data = rd_pipe[MEM_LATENCY-1];

   // Bank busy for the access cycle and the following MEM_LATENCY-1
   always_ff @(posedge clk) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         if (rst) begin
            busy_cnt[b] <= '0;
         end else if (access && bank == BANK_W'(b)) begin
            busy_cnt[b] <= BUSY_W'(MEM_LATENCY - 1);
         end else if (busy_cnt[b] != '0) begin
            busy_cnt[b] <= busy_cnt[b] - 1'b1;
         end
      end
   end

   always_comb begin
      for (int b = 0; b < NUM_BANKS; b++) begin
         busy[b] = (busy_cnt[b] != '0);
      end
   end

   assign err = access & busy[bank];

   a_one_strobe: assert property (@(posedge clk) disable iff (rst)
      !(req.rd && req.wr));

   // Controller spreads a line over all four banks
   a_bank_free: assert property (@(posedge clk) disable iff (rst)
      access |-> !busy[bank]);

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
/* Cache controller FSM
   Lookup, victim choice with LRU, dirty write-back and line refill,
   done and stall generation, read data hold and request error check */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl
   import mem_sys_pkg::*;
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           rd,
   input  wire                           wr,
   input  wire [ADDR_W-1:0]              addr,
   input  wire [DATA_W-1:0]              data_in,
   input  wire way_stat_t [NUM_WAYS-1:0] way_stat,
   output way_cmd_t                      way_cmd,
   output logic [NUM_WAYS-1:0]           way_we,
   output mem_req_t                      mem_req,
   input  wire [DATA_W-1:0]              mem_rd_data,
   output logic                          done,
   output logic                          stall,
   output logic                          cache_hit,
   output logic [DATA_W-1:0]             data_out,
   output logic                          err
);

   ctrl_state_t         state;
   addr_fields_t        req_addr;
   logic                req_wr;
   logic [DATA_W-1:0]   req_data;
   logic [CNT_W-1:0]    cnt;
   logic [CNT_W-1:0]    ret_cnt;
   logic                victim;
   logic                victim_sel;
   logic [NUM_SETS-1:0] lru;
   logic [NUM_WAYS-1:0] hit_vec;
   logic                hit_any;
   logic                hit_way;
   logic [DATA_W-1:0]   hit_data;
   logic [DATA_W-1:0]   data_hold;
   logic                bad_req;
   logic                accept;
   logic                rd_done;
   logic                fill_ret;

   assign hit_vec  = {way_stat[1].hit, way_stat[0].hit};
   assign hit_any  = |hit_vec;
   assign hit_way  = hit_vec[1];
   assign hit_data = way_stat[hit_way].data_out;

   assign done      = (state == COMPARE && hit_any) || state == FINISH;
   assign cache_hit = (state == COMPARE && hit_any);
   assign stall     = (state == COMPARE && !hit_any) || state == WRITE_BACK ||
                      state == FILL;

   // Bad requests flag err and are dropped
   assign bad_req = addr[0] | (rd & wr);
   assign err     = (rd | wr) & ~stall & bad_req;
   assign accept  = (rd | wr) & ~stall & ~bad_req & (state == IDLE || done);

   assign rd_done  = done & ~req_wr;
   assign data_out = rd_done ? hit_data : data_hold;

   // Invalid way first, way 0 before way 1, else the LRU way
   assign victim_sel = !way_stat[0].valid ? 1'b0 :
                       !way_stat[1].valid ? 1'b1 : lru[req_addr.index];

   assign ret_cnt  = cnt - CNT_W'(MEM_LATENCY);
   assign fill_ret = (state == FILL) && (cnt >= CNT_W'(MEM_LATENCY));

   always_comb begin
      way_cmd         = '0;
      way_cmd.tag_in  = req_addr.tag;
      way_cmd.index   = req_addr.index;
      way_cmd.word    = req_addr.offset[OFFSET_W-1:1];
      way_cmd.data_in = req_data;
      case (state)
         COMPARE, FINISH: begin
            way_cmd.enable = 1'b1;
            way_cmd.comp   = 1'b1;
            way_cmd.write  = req_wr;
         end
         WRITE_BACK: begin
            way_cmd.enable = 1'b1;
            way_cmd.word   = cnt[WORD_SEL_W-1:0];
         end
         FILL: begin
            if (fill_ret) begin
               way_cmd.enable   = 1'b1;
               way_cmd.write    = 1'b1;
               way_cmd.word     = ret_cnt[WORD_SEL_W-1:0];
               way_cmd.data_in  = mem_rd_data;
               way_cmd.valid_in = (ret_cnt == CNT_W'(WORDS_PER_LINE - 1));
            end
         end
         default: ;
      endcase
   end

   always_comb begin
      way_we = '0;
      if (state == COMPARE || state == FINISH) begin
         way_we = hit_vec & {NUM_WAYS{req_wr}};
      end else if (fill_ret) begin
         way_we[victim] = 1'b1;
      end
   end

   always_comb begin
      mem_req = '0;
      case (state)
         WRITE_BACK: begin
            mem_req.wr    = 1'b1;
            mem_req.addr  = {way_stat[victim].tag_out, req_addr.index,
                             cnt[WORD_SEL_W-1:0]};
            mem_req.wdata = way_stat[victim].data_out;
         end
         FILL: begin
            if (cnt < CNT_W'(WORDS_PER_LINE)) begin
               mem_req.rd   = 1'b1;
               mem_req.addr = {req_addr.tag, req_addr.index, cnt[WORD_SEL_W-1:0]};
            end
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req_addr <= addr_fields_t'(addr);
         req_data <= data_in;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= IDLE;
         cnt       <= '0;
         victim    <= 1'b0;
         req_wr    <= 1'b0;
         lru       <= '0;
         data_hold <= '0;
      end else begin
         if (accept) begin
            req_wr <= wr;
         end
         if (rd_done) begin
            data_hold <= hit_data;
         end
         // Other way becomes the eviction candidate
         if (done) begin
            lru[req_addr.index] <= ~hit_way;
         end
         case (state)
            IDLE: begin
               if (accept) begin
                  state <= COMPARE;
               end
            end
            COMPARE: begin
               if (hit_any) begin
                  state <= accept ? COMPARE : IDLE;
               end else begin
                  victim <= victim_sel;
                  cnt    <= '0;
                  state  <= (way_stat[victim_sel].valid && way_stat[victim_sel].dirty) ?
                            WRITE_BACK : FILL;
               end
            end
            WRITE_BACK: begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(WORDS_PER_LINE - 1)) begin
                  cnt   <= '0;
                  state <= FILL;
               end
            end
            FILL: begin
               cnt <= cnt + 1'b1;
               if (cnt == CNT_W'(FILL_CYCLES - 1)) begin
                  cnt   <= '0;
                  state <= FINISH;
               end
            end
            FINISH: begin
               state <= accept ? COMPARE : IDLE;
            end
            default: state <= IDLE;
         endcase
      end
   end

   // A lookup only ever starts from a cycle with stall low
   a_no_accept_in_stall: assert property (@(posedge clk) disable iff (rst)
      stall |=> state != COMPARE);

endmodule

`default_nettype wire

/* verilog/mem_system.sv */
/* Memory system top level
   Controller, two cache ways and the banked main memory */
`timescale 1ns/10ps
`default_nettype none

module mem_system
   import mem_sys_pkg::*;
(
   input  wire                clk,
   input  wire                rst,
   input  wire [ADDR_W-1:0]   addr,
   input  wire [DATA_W-1:0]   data_in,
   input  wire                rd,
   input  wire                wr,
   output logic [DATA_W-1:0]  data_out,
   output logic               done,
   output logic               stall,
   output logic               cache_hit,
   output logic               err
);

   way_cmd_t                  way_cmd;
   logic [NUM_WAYS-1:0]       way_we;
   way_stat_t [NUM_WAYS-1:0]  way_stat;
   mem_req_t                  mem_req;
   logic [DATA_W-1:0]         mem_rd_data;
   logic                      ctrl_err;
   logic                      mem_err;

   cache_ctrl u_ctrl (
      .clk         (clk),
      .rst         (rst),
      .rd          (rd),
      .wr          (wr),
      .addr        (addr),
      .data_in     (data_in),
      .way_stat    (way_stat),
      .way_cmd     (way_cmd),
      .way_we      (way_we),
      .mem_req     (mem_req),
      .mem_rd_data (mem_rd_data),
      .done        (done),
      .stall       (stall),
      .cache_hit   (cache_hit),
      .data_out    (data_out),
      .err         (ctrl_err)
   );

   // Same command to both ways, way_we picks the one that writes
   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      cache_way u_way (
         .clk  (clk),
         .rst  (rst),
         .cmd  (way_cmd),
         .we   (way_we[w]),
         .stat (way_stat[w])
      );
   end

   bank_mem u_mem (
      .clk     (clk),
      .rst     (rst),
      .req     (mem_req),
      .rd_data (mem_rd_data),
      .busy    (),
      .err     (mem_err)
   );

   assign err = ctrl_err | mem_err;

endmodule

`default_nettype wire

/* sim/tb_mem_system.sv */
/* Testbench for the cache memory system
   Seeded random reads and writes over a small address pool, flat memory
   model with a two-way tag and LRU model, latency, hold and error checks */
`timescale 1ns/10ps
`default_nettype none

module tb_mem_system
   import mem_sys_pkg::*;
();

   localparam int NUM_REQ        = 2000;
   localparam int RESET_CYCLES   = 10;
   localparam int CLK_PERIOD     = 100;
   localparam int CYCLES_PER_REQ = 20;

   logic              clk;
   logic              rst;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] data_in;
   logic              rd;
   logic              wr;
   logic [DATA_W-1:0] data_out;
   logic              done;
   logic              stall;
   logic              cache_hit;
   logic              err;

   logic [DATA_W-1:0] mem_model   [MEM_WORDS];
   logic [TAG_W-1:0]  tag_model   [NUM_WAYS][NUM_SETS];
   logic              valid_model [NUM_WAYS][NUM_SETS];
   logic              lru_model   [NUM_SETS];
   logic [DATA_W-1:0] last_read;
   integer            seed;

   mem_system DUT (
      .clk       (clk),
      .rst       (rst),
      .addr      (addr),
      .data_in   (data_in),
      .rd        (rd),
      .wr        (wr),
      .data_out  (data_out),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s, got %0h expected %0h", $time, what, got, exp);
         $display("Result: FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // Four tags over four sets, so lines conflict and get evicted dirty
   function automatic logic [ADDR_W-1:0] pick_address(input logic [31:0] r);
      logic [TAG_W-1:0]   tag;
      logic [INDEX_W-1:0] index;
      case (r[1:0])
         2'd0:    tag = 5'd0;
         2'd1:    tag = 5'd9;
         2'd2:    tag = 5'd22;
         default: tag = 5'd31;
      endcase
      case (r[3:2])
         2'd0:    index = 8'h00;
         2'd1:    index = 8'h01;
         2'd2:    index = 8'h5a;
         default: index = 8'hff;
      endcase
      return {tag, index, r[5:4], 1'b0};
   endfunction

   // Predicts a hit and applies the same fill and LRU update as the cache
   task automatic lookup_model(input logic [ADDR_W-1:0] a, output logic hit);
      addr_fields_t f;
      logic         way;
      f   = addr_fields_t'(a);
      hit = 1'b0;
      way = 1'b0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         if (valid_model[w][f.index] && tag_model[w][f.index] == f.tag) begin
            hit = 1'b1;
            way = (w == 1);
         end
      end
      if (!hit) begin
         if (!valid_model[0][f.index]) begin
            way = 1'b0;
         end else if (!valid_model[1][f.index]) begin
            way = 1'b1;
         end else begin
            way = lru_model[f.index];
         end
         tag_model[way][f.index]   = f.tag;
         valid_model[way][f.index] = 1'b1;
      end
      lru_model[f.index] = ~way;
   endtask

   task automatic run_access(input logic is_wr, input logic [ADDR_W-1:0] a,
                             input logic [DATA_W-1:0] d);
      logic              exp_hit;
      logic [31:0]       rnd;
      logic [WORD_AW-1:0] waddr;
      waddr = a[ADDR_W-1:1];
      lookup_model(a, exp_hit);
      @(posedge clk);
      #1;
      rd      = ~is_wr;
      wr      = is_wr;
      addr    = a;
      data_in = d;
      @(negedge clk);
      check_value(32'(err), 32'd0, "err on a valid request");
      check_value(32'(stall), 32'd0, "stall in the request cycle");
      @(posedge clk);
      #1;
      rnd     = $random(seed);
      rd      = 1'b0;
      wr      = 1'b0;
      addr    = rnd[15:0];
      data_in = rnd[31:16];
      @(negedge clk);
      while (!done) begin
         check_value(32'(exp_hit), 32'd0, "no done one cycle after a predicted hit");
         check_value(32'(stall), 32'd1, "stall low while a miss is served");
         check_value(32'(err), 32'd0, "err while a miss is served");
         @(negedge clk);
      end
      check_value(32'(cache_hit), 32'(exp_hit), "cache_hit at done");
      check_value(32'(stall), 32'd0, "stall at done");
      check_value(32'(err), 32'd0, "err at done");
      if (is_wr) begin
         mem_model[waddr] = d;
         check_value(32'(data_out), 32'(last_read), "data_out changed on a write");
      end else begin
         check_value(32'(data_out), 32'(mem_model[waddr]), "read data");
         last_read = mem_model[waddr];
      end
   endtask

   // Dropped request raises err in its own cycle only
   task automatic run_bad_request(input logic [ADDR_W-1:0] a, input logic rd_v,
                                  input logic wr_v);
      logic [31:0] rnd;
      rnd = $random(seed);
      @(posedge clk);
      #1;
      rd      = rd_v;
      wr      = wr_v;
      addr    = a;
      data_in = rnd[15:0];
      @(negedge clk);
      check_value(32'(err), 32'd1, "err on a bad request");
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
      @(negedge clk);
      check_value(32'(done), 32'd0, "done after a bad request");
      check_value(32'(stall), 32'd0, "stall after a bad request");
      check_value(32'(err), 32'd0, "err held after a bad request");
   endtask

   task automatic idle_cycles(input int n);
      logic [31:0] rnd;
      repeat (n) begin
         @(posedge clk);
         #1;
         rnd     = $random(seed);
         addr    = rnd[15:0];
         data_in = rnd[31:16];
         @(negedge clk);
         check_value(32'(done), 32'd0, "done without a request");
         check_value(32'(stall), 32'd0, "stall without a request");
         check_value(32'(data_out), 32'(last_read), "data_out hold");
      end
   endtask

   initial begin
      #(CLK_PERIOD * (RESET_CYCLES + NUM_REQ * CYCLES_PER_REQ + 10));
      $display("Timeout: the memory system stopped completing requests");
      $display("Result: FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      logic [31:0]       rnd;
      logic [31:0]       sel;
      logic [ADDR_W-1:0] a;
      seed      = 69210;
      clk       = 1'b0;
      rst       = 1'b1;
      rd        = 1'b0;
      wr        = 1'b0;
      addr      = '0;
      data_in   = '0;
      last_read = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem_model[i] = '0;
      end
      for (int s = 0; s < NUM_SETS; s++) begin
         valid_model[0][s] = 1'b0;
         valid_model[1][s] = 1'b0;
         lru_model[s]      = 1'b0;
      end

      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      rst = 1'b0;
      @(negedge clk);
      check_value(32'(done), 32'd0, "done after reset");
      check_value(32'(stall), 32'd0, "stall after reset");
      check_value(32'(cache_hit), 32'd0, "cache_hit after reset");
      check_value(32'(err), 32'd0, "err after reset");
      check_value(32'(data_out), 32'd0, "data_out after reset");

      for (int i = 0; i < NUM_REQ; i++) begin
         rnd = $random(seed);
         sel = $random(seed);
         a   = pick_address(rnd);
         if (i == 0) begin
            run_access(1'b0, a, '0);
         end else if (sel[4:0] == 5'd0) begin
            if (sel[5]) begin
               run_bad_request(a | 16'h0001, ~sel[6], sel[6]);
            end else begin
               run_bad_request(a, 1'b1, 1'b1);
            end
         end else begin
            run_access(sel[6], a, sel[31:16]);
         end
         idle_cycles(sel[7] ? 2 : 1);
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

/* project.f */
verilog/mem_sys_pkg.sv
verilog/cache_way.sv
verilog/bank_mem.sv
verilog/cache_ctrl.sv
verilog/mem_system.sv
sim/tb_mem_system.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
   --top-module tb_mem_system -f project.f -o tb_mem_system
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_mem_system > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Result: FAILED" "$log"; then
   echo "Simulation reported a failure"
   exit 1
fi

if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

echo "Simulation finished without failures"
exit 0
